// ==== design/act_table.sv ====
`default_nettype none

module act_table
    import parser_pkg::*;
(
    input  wire                 axis_clk,

    input  wire                 we_i,
    input  wire [TBL_IDX_W-1:0] waddr_i,
    input  wire act_entry_t     wdata_i,

    input  wire                 rd_en_i,
    input  wire [TBL_IDX_W-1:0] raddr_i,
    output act_entry_t          entry_o
);

    act_entry_t mem [TBL_DEPTH];

    always_ff @(posedge axis_clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // entry is held until the next first beat
    always_ff @(posedge axis_clk) begin
        if (rd_en_i) begin
            entry_o <= mem[raddr_i];
        end
    end

    // table is only reloaded while the data stream is idle
    a_no_rw_overlap: assert property (
        @(posedge axis_clk)
        !(we_i && rd_en_i)
    ) else $error("table write and read in the same cycle");

endmodule

`default_nettype wire

// ==== design/cfg_loader.sv ====
`default_nettype none

module cfg_loader
    import parser_pkg::*;
#(
    parameter int unsigned PARSER_ID = 0
) (
    input  wire                   axis_clk,
    input  wire                   aresetn,

    input  wire                   c_s_axis_valid_i,
    input  wire axis_beat_t       c_s_axis_i,

    output logic                  c_m_axis_valid_o,
    output axis_beat_t            c_m_axis_o,

    output logic                  tbl_we_o,
    output logic [TBL_IDX_W-1:0]  tbl_waddr_o,
    output act_entry_t            tbl_wdata_o
);

    cfg_state_e             state;
    logic [TBL_IDX_W-1:0]   index;
    // inside a forwarded packet, so no header check
    logic                   fwd_mid;
    logic [7:0]             mod_id;
    logic [15:0]            flag;
    logic                   is_hdr;
    logic [N_ACT*16-1:0]    entry_bits;

    assign mod_id = c_s_axis_i.tdata[MOD_ID_BYTE*8 +: 8];
    assign flag   = c_s_axis_i.tdata[FLAG_LSB +: 16];
    assign is_hdr = c_s_axis_valid_i && (state == CFG_IDLE) && !fwd_mid &&
                    (mod_id[2:0] == PARSER_ID[2:0]) && (flag == CFG_FLAG);

    // bytes 0..11, byte 0 most significant
    always_comb begin
        for (int j = 0; j < N_ACT*2; j++) begin
            entry_bits[N_ACT*16-1-8*j -: 8] = c_s_axis_i.tdata[8*j +: 8];
        end
    end

    assign tbl_we_o    = c_s_axis_valid_i && (state == CFG_WRITE);
    assign tbl_waddr_o = index;
    assign tbl_wdata_o = act_entry_t'(entry_bits);

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state            <= CFG_IDLE;
            index            <= '0;
            fwd_mid          <= 1'b0;
            c_m_axis_valid_o <= 1'b0;
        end else begin
            c_m_axis_valid_o <= 1'b0;
            case (state)
                CFG_IDLE: begin
                    if (is_hdr) begin
                        index <= c_s_axis_i.tdata[INDEX_BYTE*8 +: TBL_IDX_W];
                        state <= CFG_WRITE;
                    end else if (c_s_axis_valid_i) begin
                        c_m_axis_valid_o <= 1'b1;
                        fwd_mid          <= !c_s_axis_i.tlast;
                    end
                end
                CFG_WRITE: begin
                    if (c_s_axis_valid_i) begin
                        index <= index + 1'b1;
                        if (c_s_axis_i.tlast) begin
                            state <= CFG_IDLE;
                        end
                    end
                end
                default: state <= CFG_IDLE;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (c_s_axis_valid_i && (state == CFG_IDLE) && !is_hdr) begin
            c_m_axis_o <= c_s_axis_i;
        end
    end

    a_no_fwd_in_write: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        (state == CFG_WRITE) |=> !c_m_axis_valid_o
    ) else $error("control beat forwarded while writing the table");

endmodule

`default_nettype wire

// ==== design/field_extractor.sv ====
`default_nettype none

module field_extractor
    import parser_pkg::*;
(
    input  wire                axis_clk,
    input  wire                aresetn,

    input  wire                en_i,
    input  wire parse_action_t action_i,
    input  wire [WIN_W-1:0]    window_i,

    output field_t             field_o
);

    // six zero bytes past byte 127
    logic [WIN_W+47:0] win_ext;
    logic [47:0]       raw;
    logic [47:0]       value;

    assign win_ext = {48'b0, window_i};

    // first byte at offset lands in the msb
    always_comb begin
        for (int j = 0; j < 6; j++) begin
            raw[47-8*j -: 8] = win_ext[(int'(action_i.byte_offset) + j) * 8 +: 8];
        end
    end

    always_comb begin
        case (action_i.kind)
            KIND_2B: value = {32'b0, raw[47:32]};
            KIND_4B: value = {16'b0, raw[47:16]};
            KIND_6B: value = raw;
            default: value = '0;
        endcase
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            field_o <= '0;
        end else if (en_i) begin
            field_o <= '{kind: action_i.kind, slot: action_i.slot, value: value};
        end else begin
            field_o.kind <= KIND_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== design/hdr_window.sv ====
`default_nettype none

module hdr_window
    import parser_pkg::*;
(
    input  wire               axis_clk,
    input  wire               aresetn,

    input  wire               load_lo_i,
    input  wire               load_hi_i,
    input  wire               s_last_i,
    input  wire  [DATA_W-1:0] s_tdata_i,

    output logic [WIN_W-1:0]  window_o,
    output logic [11:0]       vlan_id_o
);

    logic [15:0] in_tci;
    logic [15:0] win_tci;

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            window_o <= '0;
        end else if (load_lo_i) begin
            window_o[DATA_W-1:0] <= s_tdata_i;
            // single-beat packet, upper half reads as zero
            if (s_last_i) begin
                window_o[WIN_W-1:DATA_W] <= '0;
            end
        end else if (load_hi_i) begin
            window_o[WIN_W-1:DATA_W] <= s_tdata_i;
        end
    end

    // tag control word at bytes 14..15, big endian
    assign in_tci  = {s_tdata_i[14*8 +: 8], s_tdata_i[15*8 +: 8]};
    assign win_tci = {window_o[14*8 +: 8], window_o[15*8 +: 8]};

    // incoming beat on a first beat so the table read sees it on that edge,
    // otherwise the first beat already held in the window
    always_comb begin
        if (load_lo_i) begin
            vlan_id_o = in_tci[11:0];
        end else begin
            vlan_id_o = win_tci[11:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/parse_ctrl.sv ====
`default_nettype none

module parse_ctrl
    import parser_pkg::*;
(
    input  wire  axis_clk,
    input  wire  aresetn,

    input  wire  s_axis_valid_i,
    input  wire  s_last_i,

    output logic load_lo_o,
    output logic load_hi_o,
    output logic rd_en_o,
    output logic win_done_o
);

    beat_pos_e pos;
    // window already complete, rest of packet is ignored
    logic      past_hdr;
    logic      done_now;

    assign load_lo_o = s_axis_valid_i && (pos == POS_FIRST);
    assign load_hi_o = s_axis_valid_i && (pos == POS_SECOND) && !past_hdr;
    assign rd_en_o   = load_lo_o;
    assign done_now  = load_hi_o || (load_lo_o && s_last_i);

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            pos        <= POS_FIRST;
            past_hdr   <= 1'b0;
            win_done_o <= 1'b0;
        end else begin
            win_done_o <= done_now;
            if (s_axis_valid_i) begin
                if (s_last_i) begin
                    pos      <= POS_FIRST;
                    past_hdr <= 1'b0;
                end else if (pos == POS_FIRST) begin
                    pos <= POS_SECOND;
                end else begin
                    past_hdr <= 1'b1;
                end
            end
        end
    end

    // low and high half of the window never load on the same edge
    a_load_excl: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        !(load_lo_o && load_hi_o)
    ) else $error("load_lo and load_hi high together");

endmodule

`default_nettype wire

// ==== design/parser_pkg.sv ====
`default_nettype none

package parser_pkg;

    localparam int DATA_W    = 512;
    localparam int KEEP_W    = DATA_W / 8;
    localparam int USER_W    = 128;
    localparam int WIN_W     = 2 * DATA_W;
    localparam int N_ACT     = 6;
    localparam int TBL_DEPTH = 16;
    localparam int TBL_IDX_W = 4;

    localparam logic [15:0] CFG_FLAG = 16'hf2f1;

    // control header layout
    localparam int MOD_ID_BYTE = 46;
    localparam int FLAG_LSB    = 320;
    localparam int INDEX_BYTE  = 48;

    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [KEEP_W-1:0] tkeep;
        logic [USER_W-1:0] tuser;
        logic              tlast;
    } axis_beat_t;

    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_2B   = 2'd1,
        KIND_4B   = 2'd2,
        KIND_6B   = 2'd3
    } field_kind_e;

    typedef struct packed {
        field_kind_e kind;
        logic [1:0]  slot;
        logic [6:0]  byte_offset;
        logic [4:0]  rsvd;
    } parse_action_t;

    // action 0 sits in the top 16 bits
    typedef parse_action_t [0:N_ACT-1] act_entry_t;

    typedef struct packed {
        field_kind_e kind;
        logic [1:0]  slot;
        logic [47:0] value;
    } field_t;

    typedef struct packed {
        logic [0:3][47:0] c6;
        logic [0:3][31:0] c4;
        logic [0:3][15:0] c2;
        logic [11:0]      vlan_id;
    } phv_t;

    typedef enum logic {
        POS_FIRST  = 1'b0,
        POS_SECOND = 1'b1
    } beat_pos_e;

    typedef enum logic {
        CFG_IDLE  = 1'b0,
        CFG_WRITE = 1'b1
    } cfg_state_e;

endpackage

`default_nettype wire

// ==== design/parser_top.sv ====
`default_nettype none

module parser_top
    import parser_pkg::*;
#(
    parameter int unsigned PARSER_ID = 0
) (
    input  wire        axis_clk,
    input  wire        aresetn,

    input  wire        s_axis_valid_i,
    input  wire        axis_beat_t s_axis_i,

    output logic       phv_valid_o,
    output phv_t       phv_o,

    input  wire        c_s_axis_valid_i,
    input  wire        axis_beat_t c_s_axis_i,

    output logic       c_m_axis_valid_o,
    output axis_beat_t c_m_axis_o
);

    logic                 load_lo;
    logic                 load_hi;
    logic                 rd_en;
    logic                 win_done;
    logic [WIN_W-1:0]     window;
    logic [11:0]          vlan_id;
    act_entry_t           entry;
    field_t [N_ACT-1:0]   fields;
    logic                 tbl_we;
    logic [TBL_IDX_W-1:0] tbl_waddr;
    act_entry_t           tbl_wdata;

    parse_ctrl parse_ctrl_i (
        .axis_clk       (axis_clk),
        .aresetn        (aresetn),
        .s_axis_valid_i (s_axis_valid_i),
        .s_last_i       (s_axis_i.tlast),
        .load_lo_o      (load_lo),
        .load_hi_o      (load_hi),
        .rd_en_o        (rd_en),
        .win_done_o     (win_done)
    );

    hdr_window hdr_window_i (
        .axis_clk  (axis_clk),
        .aresetn   (aresetn),
        .load_lo_i (load_lo),
        .load_hi_i (load_hi),
        .s_last_i  (s_axis_i.tlast),
        .s_tdata_i (s_axis_i.tdata),
        .window_o  (window),
        .vlan_id_o (vlan_id)
    );

    // table index is vlan_id[7:4]
    act_table act_table_i (
        .axis_clk (axis_clk),
        .we_i     (tbl_we),
        .waddr_i  (tbl_waddr),
        .wdata_i  (tbl_wdata),
        .rd_en_i  (rd_en),
        .raddr_i  (vlan_id[7:4]),
        .entry_o  (entry)
    );

    for (genvar i = 0; i < N_ACT; i++) begin : g_ext
        field_extractor field_extractor_i (
            .axis_clk (axis_clk),
            .aresetn  (aresetn),
            .en_i     (win_done),
            .action_i (entry[i]),
            .window_i (window),
            .field_o  (fields[i])
        );
    end

    phv_assembler phv_assembler_i (
        .axis_clk    (axis_clk),
        .aresetn     (aresetn),
        .fields_i    (fields),
        .vlan_id_i   (vlan_id),
        .valid_i     (win_done),
        .phv_o       (phv_o),
        .phv_valid_o (phv_valid_o)
    );

    cfg_loader #(
        .PARSER_ID (PARSER_ID)
    ) cfg_loader_i (
        .axis_clk         (axis_clk),
        .aresetn          (aresetn),
        .c_s_axis_valid_i (c_s_axis_valid_i),
        .c_s_axis_i       (c_s_axis_i),
        .c_m_axis_valid_o (c_m_axis_valid_o),
        .c_m_axis_o       (c_m_axis_o),
        .tbl_we_o         (tbl_we),
        .tbl_waddr_o      (tbl_waddr),
        .tbl_wdata_o      (tbl_wdata)
    );

endmodule

`default_nettype wire

// ==== design/phv_assembler.sv ====
`default_nettype none

module phv_assembler
    import parser_pkg::*;
(
    input  wire                     axis_clk,
    input  wire                     aresetn,

    input  wire field_t [N_ACT-1:0] fields_i,
    input  wire [11:0]              vlan_id_i,
    input  wire                     valid_i,

    output phv_t                    phv_o,
    output logic                    phv_valid_o
);

    // vlan is sampled on the completing edge, two stages to meet the fields
    logic [11:0] vlan_d1;
    logic [11:0] vlan_d2;
    logic        valid_d;
    phv_t        phv_next;

    always_ff @(posedge axis_clk) begin
        vlan_d1 <= vlan_id_i;
        vlan_d2 <= vlan_d1;
    end

    // higher action overwrites a shared slot
    always_comb begin
        phv_next = '0;
        for (int i = 0; i < N_ACT; i++) begin
            case (fields_i[i].kind)
                KIND_2B: phv_next.c2[fields_i[i].slot] = fields_i[i].value[15:0];
                KIND_4B: phv_next.c4[fields_i[i].slot] = fields_i[i].value[31:0];
                KIND_6B: phv_next.c6[fields_i[i].slot] = fields_i[i].value;
                default: ;
            endcase
        end
        phv_next.vlan_id = vlan_d2;
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            valid_d     <= 1'b0;
            phv_valid_o <= 1'b0;
            phv_o       <= '0;
        end else begin
            valid_d     <= valid_i;
            phv_valid_o <= valid_d;
            if (valid_d) begin
                phv_o <= phv_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== parser_top.f ====
design/parser_pkg.sv
design/parse_ctrl.sv
design/hdr_window.sv
design/act_table.sv
design/field_extractor.sv
design/phv_assembler.sv
design/cfg_loader.sv
design/parser_top.sv
sim/tb_parser_top.sv

// ==== sim/tb_parser_top.sv ====
`default_nettype none

module tb_parser_top
    import parser_pkg::*;
();

    localparam int unsigned PARSER_ID = 0;
    // roughly 250 cycles of traffic, large margin
    localparam int TIMEOUT = 3000;

    logic       axis_clk;
    logic       aresetn;
    logic       s_axis_valid_i;
    axis_beat_t s_axis_i;
    logic       phv_valid_o;
    phv_t       phv_o;
    logic       c_s_axis_valid_i;
    axis_beat_t c_s_axis_i;
    logic       c_m_axis_valid_o;
    axis_beat_t c_m_axis_o;

    act_entry_t        tbl_model [TBL_DEPTH];
    phv_t              phv_q [$];
    int                stamp_q [$];
    phv_t              exp_head;
    int                exp_stamp;
    logic              exp_valid;
    int                cycle = 0;

    // data stream position as the reference model sees it
    logic              in_second;
    logic              in_tail;
    logic [DATA_W-1:0] lo_beat;
    logic [WIN_W-1:0]  mon_win;
    logic              win_cmp;

    // control stream state as the reference model sees it
    logic              cfg_wr;
    logic              cfg_mid;
    logic              cfg_hdr;
    logic              fwd_exp;
    axis_beat_t        fwd_ref;

    parser_top #(
        .PARSER_ID (PARSER_ID)
    ) parser_top_i (
        .axis_clk         (axis_clk),
        .aresetn          (aresetn),
        .s_axis_valid_i   (s_axis_valid_i),
        .s_axis_i         (s_axis_i),
        .phv_valid_o      (phv_valid_o),
        .phv_o            (phv_o),
        .c_s_axis_valid_i (c_s_axis_valid_i),
        .c_s_axis_i       (c_s_axis_i),
        .c_m_axis_valid_o (c_m_axis_valid_o),
        .c_m_axis_o       (c_m_axis_o)
    );

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic logic [DATA_W-1:0] rand_data();
        logic [DATA_W-1:0] d;
        for (int w = 0; w < DATA_W / 32; w++) begin
            d[32*w +: 32] = $urandom;
        end
        return d;
    endfunction

    function automatic parse_action_t mk_act(input field_kind_e kind, input logic [1:0] slot,
                                             input logic [6:0] off);
        parse_action_t a;
        a.kind        = kind;
        a.slot        = slot;
        a.byte_offset = off;
        a.rsvd        = '0;
        return a;
    endfunction

    function automatic parse_action_t rand_action();
        logic [15:0] r;
        r = 16'($urandom);
        return r;
    endfunction

    // big-endian fields, bytes past 127 read as zero
    function automatic phv_t expect_phv(input logic [WIN_W-1:0] win, input act_entry_t ent);
        phv_t        p;
        logic [47:0] v;
        int          n;
        int          o;
        p = '0;
        for (int i = 0; i < N_ACT; i++) begin
            case (ent[i].kind)
                KIND_2B: n = 2;
                KIND_4B: n = 4;
                KIND_6B: n = 6;
                default: n = 0;
            endcase
            v = '0;
            for (int b = 0; b < n; b++) begin
                o = int'(ent[i].byte_offset) + b;
                if (o < 128) begin
                    v = {v[39:0], win[o*8 +: 8]};
                end else begin
                    v = {v[39:0], 8'h00};
                end
            end
            case (ent[i].kind)
                KIND_2B: p.c2[ent[i].slot] = v[15:0];
                KIND_4B: p.c4[ent[i].slot] = v[31:0];
                KIND_6B: p.c6[ent[i].slot] = v;
                default: ;
            endcase
        end
        p.vlan_id = {win[8*14 +: 4], win[8*15 +: 8]};
        return p;
    endfunction

    task automatic drive_data(input logic vld, input logic [DATA_W-1:0] d, input logic last);
        @(posedge axis_clk);
        #1;
        s_axis_valid_i = vld;
        s_axis_i.tdata = d;
        s_axis_i.tkeep = '1;
        s_axis_i.tuser = '0;
        s_axis_i.tlast = last;
    endtask

    task automatic drive_ctrl(input logic vld, input logic [DATA_W-1:0] d, input logic last);
        @(posedge axis_clk);
        #1;
        c_s_axis_valid_i = vld;
        c_s_axis_i.tdata = d;
        c_s_axis_i.tkeep = '1;
        c_s_axis_i.tuser = {$urandom, $urandom, $urandom, $urandom};
        c_s_axis_i.tlast = last;
    endtask

    task automatic send_packet(input logic [3:0] idx, input int nbeats);
        logic [DATA_W-1:0] d;
        for (int k = 0; k < nbeats; k++) begin
            d = rand_data();
            // table index sits in vlan bits 7:4
            if (k == 0) begin
                d[15*8+4 +: 4] = idx;
            end
            drive_data(1'b1, d, k == nbeats - 1);
        end
    endtask

    task automatic drain();
        drive_data(1'b0, '0, 1'b0);
        while (phv_q.size() != 0) begin
            @(posedge axis_clk);
        end
    endtask

    task automatic write_table(input int first, input int n);
        logic [DATA_W-1:0]   d;
        logic [N_ACT*16-1:0] bits;
        d = rand_data();
        d[MOD_ID_BYTE*8 +: 3] = PARSER_ID[2:0];
        d[FLAG_LSB +: 16]     = CFG_FLAG;
        d[INDEX_BYTE*8 +: 8]  = 8'(first);
        drive_ctrl(1'b1, d, 1'b0);
        for (int k = 0; k < n; k++) begin
            bits = tbl_model[(first + k) % TBL_DEPTH];
            d    = rand_data();
            for (int j = 0; j < N_ACT * 2; j++) begin
                d[8*j +: 8] = bits[N_ACT*16-1-8*j -: 8];
            end
            drive_ctrl(1'b1, d, k == n - 1);
        end
        drive_ctrl(1'b0, '0, 1'b0);
    endtask

    task automatic send_foreign(input logic [2:0] mod_id, input logic [15:0] flag);
        logic [DATA_W-1:0] d;
        d = rand_data();
        d[MOD_ID_BYTE*8 +: 3] = mod_id;
        d[FLAG_LSB +: 16]     = flag;
        drive_ctrl(1'b1, d, 1'b0);
        drive_ctrl(1'b1, rand_data(), 1'b1);
        drive_ctrl(1'b0, '0, 1'b0);
    endtask

    assign win_cmp = s_axis_valid_i && (in_second ? !in_tail : s_axis_i.tlast);
    assign cfg_hdr = c_s_axis_valid_i && !cfg_wr && !cfg_mid &&
                     (c_s_axis_i.tdata[MOD_ID_BYTE*8 +: 3] == PARSER_ID[2:0]) &&
                     (c_s_axis_i.tdata[FLAG_LSB +: 16] == CFG_FLAG);
    assign fwd_exp = c_s_axis_valid_i && !cfg_wr && !cfg_hdr;

    // reference model for the data stream
    always @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            in_second <= 1'b0;
            in_tail   <= 1'b0;
            exp_valid <= 1'b0;
            phv_q.delete();
            stamp_q.delete();
        end else begin
            if (phv_valid_o && phv_q.size() > 0) begin
                void'(phv_q.pop_front());
                void'(stamp_q.pop_front());
            end
            if (win_cmp) begin
                mon_win = in_second ? {s_axis_i.tdata, lo_beat}
                                    : {{DATA_W{1'b0}}, s_axis_i.tdata};
                phv_q.push_back(expect_phv(mon_win, tbl_model[mon_win[15*8+4 +: 4]]));
                stamp_q.push_back(cycle);
            end
            exp_valid <= phv_q.size() > 0;
            if (phv_q.size() > 0) begin
                exp_head  <= phv_q[0];
                exp_stamp <= stamp_q[0];
            end
            if (s_axis_valid_i) begin
                if (!in_second) begin
                    lo_beat <= s_axis_i.tdata;
                end
                if (s_axis_i.tlast) begin
                    in_second <= 1'b0;
                    in_tail   <= 1'b0;
                end else if (!in_second) begin
                    in_second <= 1'b1;
                end else begin
                    in_tail <= 1'b1;
                end
            end
        end
    end

    always @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            cfg_wr  <= 1'b0;
            cfg_mid <= 1'b0;
        end else if (c_s_axis_valid_i) begin
            if (fwd_exp) begin
                fwd_ref <= c_s_axis_i;
            end
            if (cfg_wr) begin
                if (c_s_axis_i.tlast) begin
                    cfg_wr <= 1'b0;
                end
            end else if (cfg_hdr) begin
                cfg_wr <= 1'b1;
            end else begin
                cfg_mid <= !c_s_axis_i.tlast;
            end
        end
    end

    always @(posedge axis_clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            fail_now("timeout: the run did not finish within the cycle limit");
        end
    end

    a_phv_latency: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        win_cmp |-> ##3 phv_valid_o
    ) else fail_now("no PHV two cycles after a completed window");

    a_phv_order: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        phv_valid_o |-> exp_valid && (exp_stamp + 3 == cycle)
    ) else fail_now("PHV valid without a window completed two cycles earlier");

    a_phv_data: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        phv_valid_o |-> phv_o == exp_head
    ) else fail_now($sformatf("[ERROR] phv_o expected %h actual %h",
                              $sampled(exp_head), $sampled(phv_o)));

    a_fwd_valid: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        fwd_exp |=> c_m_axis_valid_o
    ) else fail_now("control beat was not forwarded one cycle later");

    a_fwd_only: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        c_m_axis_valid_o |-> $past(fwd_exp)
    ) else fail_now("forward output valid for a beat that should be consumed");

    a_fwd_data: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        c_m_axis_valid_o |-> c_m_axis_o == fwd_ref
    ) else fail_now($sformatf("[ERROR] c_m_axis_o expected %h actual %h",
                              $sampled(fwd_ref), $sampled(c_m_axis_o)));

    initial begin
        void'($urandom(32'hf68f));
        aresetn          = 1'b0;
        s_axis_valid_i   = 1'b0;
        s_axis_i         = '0;
        c_s_axis_valid_i = 1'b0;
        c_s_axis_i       = '0;
        repeat (8) @(posedge axis_clk);
        #1;
        aresetn = 1'b1;
        repeat (4) @(posedge axis_clk);
        #1;
        assert (!phv_valid_o && !c_m_axis_valid_o && phv_o == '0)
            else fail_now("outputs not idle after reset");

        // two entries, single-beat packets
        tbl_model[3] = {mk_act(KIND_6B, 0, 0), mk_act(KIND_6B, 1, 6), mk_act(KIND_2B, 0, 12),
                        mk_act(KIND_4B, 2, 26), mk_act(KIND_2B, 3, 14), mk_act(KIND_NONE, 0, 0)};
        tbl_model[4] = {mk_act(KIND_4B, 0, 30), mk_act(KIND_4B, 1, 34), mk_act(KIND_NONE, 0, 0),
                        mk_act(KIND_6B, 3, 58), mk_act(KIND_2B, 1, 23), mk_act(KIND_2B, 2, 36)};
        write_table(3, 2);
        send_packet(4'd3, 1);
        send_packet(4'd4, 1);
        drain();

        // upper half of the window, field across byte 63, reads past 127
        tbl_model[5] = {mk_act(KIND_6B, 0, 60), mk_act(KIND_4B, 1, 64), mk_act(KIND_2B, 2, 126),
                        mk_act(KIND_6B, 1, 124), mk_act(KIND_4B, 3, 100), mk_act(KIND_2B, 0, 90)};
        write_table(5, 1);
        send_packet(4'd5, 2);
        send_packet(4'd5, 1);
        drain();

        // shared slots, higher action wins
        tbl_model[6] = {mk_act(KIND_2B, 1, 16), mk_act(KIND_4B, 1, 20), mk_act(KIND_6B, 2, 40),
                        mk_act(KIND_NONE, 0, 0), mk_act(KIND_4B, 1, 30), mk_act(KIND_2B, 1, 70)};
        write_table(6, 1);
        send_packet(4'd6, 2);
        drain();

        // fill the rest, index wraps past 15
        for (int k = 7; k < 19; k++) begin
            for (int a = 0; a < N_ACT; a++) begin
                tbl_model[k % TBL_DEPTH][a] = rand_action();
            end
        end
        write_table(7, 12);
        for (int p = 0; p < 10; p++) begin
            send_packet(4'($urandom), 1 + int'($urandom % 4));
        end
        drain();

        // foreign module id, then wrong flag
        send_foreign(3'd1, CFG_FLAG);
        send_foreign(PARSER_ID[2:0], 16'hf2f0);
        repeat (4) @(posedge axis_clk);

        if (phv_q.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            fail_now("expected PHVs still pending at the end of the run");
        end
    end

endmodule

`default_nettype wire
